// File: design/gpmc_pkg.sv
// Shared widths, queue sizes and framing types for the GPMC stream bridge
package gpmc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and stream widths
   ////////////////////////////////////////////////////////////////////////////

   // Processor data bus word
   localparam int DATA_W      = 16;

   // Stream word with start of frame in bit 16 and end of frame in bit 17
   localparam int STREAM_W    = 18;

   // Each half of the chip select 6 status word
   localparam int STAT_BYTE_W = DATA_W / 2;

   ////////////////////////////////////////////////////////////////////////////
   // Queue sizing and framing
   ////////////////////////////////////////////////////////////////////////////

   localparam int FIFO_DEPTH  = 16;
   localparam int PTR_W       = $clog2(FIFO_DEPTH);

   // Fill count has to reach FIFO_DEPTH itself
   localparam int CNT_W       = 5;

   // Fixed frame length on the transmit stream
   localparam int FRAME_LEN   = 10;

   typedef enum logic {
      FRAME_IDLE = 1'b0,
      FRAME_BODY = 1'b1
   } frame_state_e;

endpackage

// File: design/gpmc_if.sv
// Bus strobe bundle and per-path status bundle shared inside the bridge
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// GPMC strobes and write data driven from the top-level pins
////////////////////////////////////////////////////////////////////////////

interface gpmc_bus_if import gpmc_pkg::*; ();

   // Active-low strobes
   logic              ncs4;
   logic              ncs6;
   logic              nwe;
   logic              noe;

   // Write data from the processor
   logic [DATA_W-1:0] d_in;

   modport listen (input ncs4, input ncs6, input nwe, input noe, input d_in);

endinterface

////////////////////////////////////////////////////////////////////////////
// Read data, drive request, error pulse and fill count of one path
////////////////////////////////////////////////////////////////////////////

interface path_status_if import gpmc_pkg::*; ();

   logic [DATA_W-1:0] rd_data;
   logic              rd_req;
   logic              err;
   logic [CNT_W-1:0]  level;

   // Path side
   modport src (output rd_data, output rd_req, output err, output level);

   // Combiner side
   modport sink (input rd_data, input rd_req, input err, input level);

endinterface

// File: design/gpmc_tx_writer.sv
// Transmit path that queues chip select 4 writes and sends them as framed stream words
`timescale 1ns/1ps

module gpmc_tx_writer import gpmc_pkg::*; (
   input  logic                em_clk_i,
   input  logic                rst_i,
   gpmc_bus_if.listen          bus,
   path_status_if.src          stat,
   output logic [STREAM_W-1:0] tx_data_o,
   output logic                tx_src_rdy_o,
   input  logic                tx_dst_rdy_i,
   output logic                tx_have_space_o
);

   logic [STREAM_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    level;
   logic [CNT_W-1:0]    free_cnt;
   logic [CNT_W-1:0]    word_cnt;
   frame_state_e        frame_state;
   logic                wr_edge;
   logic                full;
   logic                push;
   logic                pop;
   logic                sof;
   logic                eof;

   ////////////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////////////

   assign wr_edge = ~bus.ncs4 & ~bus.nwe;
   assign full    = (level == CNT_W'(FIFO_DEPTH));
   assign push    = wr_edge & ~full;

   // Flags are fixed when the word enters the queue
   assign sof = (frame_state == FRAME_IDLE);
   assign eof = (word_cnt == CNT_W'(FRAME_LEN - 1));

   always_ff @(posedge em_clk_i) begin
      if (rst_i) begin
         frame_state <= FRAME_IDLE;
         word_cnt    <= '0;
      end else if (push) begin
         if (eof) begin
            frame_state <= FRAME_IDLE;
            word_cnt    <= '0;
         end else begin
            frame_state <= FRAME_BODY;
            word_cnt    <= word_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge em_clk_i) begin
      if (push) begin
         mem[wr_ptr] <= {eof, sof, bus.d_in};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and fill count
   ////////////////////////////////////////////////////////////////////////////

   assign pop = tx_src_rdy_o & tx_dst_rdy_i;

   always_ff @(posedge em_clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // Head word goes straight out
   assign tx_data_o       = mem[rd_ptr];
   assign tx_src_rdy_o    = (level != '0);
   assign free_cnt        = CNT_W'(FIFO_DEPTH) - level;
   assign tx_have_space_o = (free_cnt >= CNT_W'(FRAME_LEN));

   // Nothing to read back on this path
   assign stat.rd_data = '0;
   assign stat.rd_req  = 1'b0;
   assign stat.err     = wr_edge & full;
   assign stat.level   = level;

   a_tx_level_bound: assert property (@(posedge em_clk_i) disable iff (rst_i)
      level <= CNT_W'(FIFO_DEPTH));

   a_tx_hold_on_stall: assert property (@(posedge em_clk_i) disable iff (rst_i)
      (tx_src_rdy_o && !tx_dst_rdy_i) |=> (tx_src_rdy_o && $stable(tx_data_o)));

endmodule

// File: design/gpmc_rx_reader.sv
// Receive path that queues stream words and returns them on chip select 4 reads
`timescale 1ns/1ps

module gpmc_rx_reader import gpmc_pkg::*; (
   input  logic                em_clk_i,
   input  logic                rst_i,
   gpmc_bus_if.listen          bus,
   path_status_if.src          stat,
   input  logic [STREAM_W-1:0] rx_data_i,
   input  logic                rx_src_rdy_i,
   output logic                rx_dst_rdy_o,
   output logic                rx_have_data_o
);

   logic [STREAM_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    level;
   logic                rd_edge;
   logic                empty;
   logic                push;
   logic                pop;

   ////////////////////////////////////////////////////////////////////////////
   // Stream side fills the queue
   ////////////////////////////////////////////////////////////////////////////

   assign rx_dst_rdy_o = (level != CNT_W'(FIFO_DEPTH));
   assign push         = rx_src_rdy_i & rx_dst_rdy_o;

   always_ff @(posedge em_clk_i) begin
      if (push) begin
         mem[wr_ptr] <= rx_data_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus side drains it
   ////////////////////////////////////////////////////////////////////////////

   assign rd_edge = ~bus.ncs4 & ~bus.noe;
   assign empty   = (level == '0);
   assign pop     = rd_edge & ~empty;

   always_ff @(posedge em_clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   // Empty queue reads back as zero and frame flags are dropped
   assign stat.rd_data = empty ? '0 : mem[rd_ptr][DATA_W-1:0];
   assign stat.rd_req  = rd_edge;
   assign stat.err     = rd_edge & empty;
   assign stat.level   = level;

   assign rx_have_data_o = ~empty;

   a_rx_level_bound: assert property (@(posedge em_clk_i) disable iff (rst_i)
      level <= CNT_W'(FIFO_DEPTH));

endmodule

// File: design/gpmc_bus_mux.sv
// Combiner for read data, output enable and the sticky bus error of both paths
`timescale 1ns/1ps

module gpmc_bus_mux import gpmc_pkg::*; (
   input  logic              em_clk_i,
   input  logic              rst_i,
   gpmc_bus_if.listen        bus,
   path_status_if.sink       tx_stat,
   path_status_if.sink       rx_stat,
   output logic [DATA_W-1:0] em_d_o,
   output logic              em_d_oe_o,
   output logic              bus_error_o,
   input  logic              bus_reset_i
);

   logic              cs6_rd;
   logic [DATA_W-1:0] path_data;
   logic [DATA_W-1:0] status_word;

   ////////////////////////////////////////////////////////////////////////////
   // Read data and drive enable
   ////////////////////////////////////////////////////////////////////////////

   assign cs6_rd = ~bus.ncs6 & ~bus.noe;

   // Tx level in the high byte and rx level in the low byte
   assign status_word = {STAT_BYTE_W'(tx_stat.level), STAT_BYTE_W'(rx_stat.level)};

   assign path_data = (tx_stat.rd_req ? tx_stat.rd_data : '0) |
                      (rx_stat.rd_req ? rx_stat.rd_data : '0);

   // Chip select 4 wins when both are low
   assign em_d_o    = ~bus.ncs4 ? path_data : status_word;
   assign em_d_oe_o = tx_stat.rd_req | rx_stat.rd_req | cs6_rd;

   ////////////////////////////////////////////////////////////////////////////
   // Sticky error
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge em_clk_i) begin
      if (rst_i || bus_reset_i) begin
         bus_error_o <= 1'b0;
      end else if (tx_stat.err || rx_stat.err) begin
         bus_error_o <= 1'b1;
      end
   end

   // Drive requests from either path must line up with a real read strobe
   a_oe_only_on_read: assert property (@(posedge em_clk_i) disable iff (rst_i)
      em_d_oe_o |-> (!bus.noe && (!bus.ncs4 || !bus.ncs6)));

endmodule

// File: design/gpmc_bridge.sv
// Top level of the GPMC to stream bridge, joining both paths and the bus combiner
`timescale 1ns/1ps

module gpmc_bridge import gpmc_pkg::*; (
   input  logic                em_clk_i,
   input  logic                rst_i,
   // GPMC pins
   input  logic [DATA_W-1:0]   em_d_i,
   output logic [DATA_W-1:0]   em_d_o,
   output logic                em_d_oe_o,
   input  logic                em_ncs4_i,
   input  logic                em_ncs6_i,
   input  logic                em_nwe_i,
   input  logic                em_noe_i,
   // Stream ports
   output logic [STREAM_W-1:0] tx_data_o,
   output logic                tx_src_rdy_o,
   input  logic                tx_dst_rdy_i,
   input  logic [STREAM_W-1:0] rx_data_i,
   input  logic                rx_src_rdy_i,
   output logic                rx_dst_rdy_o,
   // Processor side flags
   output logic                tx_have_space_o,
   output logic                rx_have_data_o,
   output logic                bus_error_o,
   input  logic                bus_reset_i
);

   gpmc_bus_if    bus_if ();
   path_status_if tx_stat ();
   path_status_if rx_stat ();

   assign bus_if.ncs4 = em_ncs4_i;
   assign bus_if.ncs6 = em_ncs6_i;
   assign bus_if.nwe  = em_nwe_i;
   assign bus_if.noe  = em_noe_i;
   assign bus_if.d_in = em_d_i;

   ////////////////////////////////////////////////////////////////////////////
   // Data paths on chip select 4
   ////////////////////////////////////////////////////////////////////////////

   gpmc_tx_writer u_tx_writer (
      .em_clk_i        (em_clk_i),
      .rst_i           (rst_i),
      .bus             (bus_if),
      .stat            (tx_stat),
      .tx_data_o       (tx_data_o),
      .tx_src_rdy_o    (tx_src_rdy_o),
      .tx_dst_rdy_i    (tx_dst_rdy_i),
      .tx_have_space_o (tx_have_space_o)
   );

   gpmc_rx_reader u_rx_reader (
      .em_clk_i       (em_clk_i),
      .rst_i          (rst_i),
      .bus            (bus_if),
      .stat           (rx_stat),
      .rx_data_i      (rx_data_i),
      .rx_src_rdy_i   (rx_src_rdy_i),
      .rx_dst_rdy_o   (rx_dst_rdy_o),
      .rx_have_data_o (rx_have_data_o)
   );

   // Status word on chip select 6 and the shared bus outputs
   gpmc_bus_mux u_bus_mux (
      .em_clk_i    (em_clk_i),
      .rst_i       (rst_i),
      .bus         (bus_if),
      .tx_stat     (tx_stat),
      .rx_stat     (rx_stat),
      .em_d_o      (em_d_o),
      .em_d_oe_o   (em_d_oe_o),
      .bus_error_o (bus_error_o),
      .bus_reset_i (bus_reset_i)
   );

endmodule

// File: verif/tb_gpmc_bridge.sv
// Testbench that replays the GPMC trace through the bridge and checks bus and stream responses
`timescale 1ns/1ps

module tb_gpmc_bridge import gpmc_pkg::*; ();

   localparam int    CLK_PERIOD = 8;
   localparam int    WAIT_LIMIT = 20;
   localparam string TRACE_FILE = "verif/gpmc_trace.txt";

   logic                clk;
   logic                rst;
   logic [DATA_W-1:0]   em_d_in;
   logic [DATA_W-1:0]   em_d_out;
   logic                em_d_oe;
   logic                ncs4;
   logic                ncs6;
   logic                nwe;
   logic                noe;
   logic [STREAM_W-1:0] tx_data;
   logic                tx_src_rdy;
   logic                tx_dst_rdy;
   logic [STREAM_W-1:0] rx_data;
   logic                rx_src_rdy;
   logic                rx_dst_rdy;
   logic                tx_have_space;
   logic                rx_have_data;
   logic                bus_error;
   logic                bus_reset;

   // Parsed trace, one entry per operation
   byte         op_q[$];
   logic [31:0] val_q[$];
   int          cnt_q[$];
   int          total_words = 0;
   bit          trace_ready = 1'b0;

   integer      seed = 33426;
   int          err_cnt = 0;
   int          check_cnt = 0;

   // Reference counts kept by the testbench
   int          tx_cnt = 0;
   int          rx_cnt = 0;
   int          tx_frame_pos = 0;

   gpmc_bridge uut (
      .em_clk_i        (clk),
      .rst_i           (rst),
      .em_d_i          (em_d_in),
      .em_d_o          (em_d_out),
      .em_d_oe_o       (em_d_oe),
      .em_ncs4_i       (ncs4),
      .em_ncs6_i       (ncs6),
      .em_nwe_i        (nwe),
      .em_noe_i        (noe),
      .tx_data_o       (tx_data),
      .tx_src_rdy_o    (tx_src_rdy),
      .tx_dst_rdy_i    (tx_dst_rdy),
      .rx_data_i       (rx_data),
      .rx_src_rdy_i    (rx_src_rdy),
      .rx_dst_rdy_o    (rx_dst_rdy),
      .tx_have_space_o (tx_have_space),
      .rx_have_data_o  (rx_have_data),
      .bus_error_o     (bus_error),
      .bus_reset_i     (bus_reset)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_cnt++;
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         err_cnt++;
      end
   endtask

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      logic [63:0] op_word;
      logic [31:0] val;
      int          cnt;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the trace file %s", TRACE_FILE);
         err_cnt++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            val  = '0;
            cnt  = 1;
            n    = $fgets(line, fd);
            // Lines starting with a hash are notes
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %d", op_word, val, cnt);
               if (n >= 1) begin
                  op_q.push_back(op_word[7:0]);
                  val_q.push_back(val);
                  cnt_q.push_back(cnt);
                  total_words += cnt;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic bus_write(input logic [31:0] base, input int count);
      int i;
      for (i = 0; i < count; i++) begin
         em_d_in = 16'(base + i);
         ncs4    = 1'b0;
         nwe     = 1'b0;
         @(negedge clk);
         // A write to a full queue is dropped
         if (tx_cnt < FIFO_DEPTH) begin
            tx_cnt++;
         end
         check_value("tx_have_space_o", 32'(tx_have_space),
                     32'((FIFO_DEPTH - tx_cnt) >= FRAME_LEN));
      end
      ncs4 = 1'b1;
      nwe  = 1'b1;
   endtask

   task automatic bus_read(input logic [31:0] base, input int count);
      int i;
      for (i = 0; i < count; i++) begin
         ncs4 = 1'b0;
         noe  = 1'b0;
         #(CLK_PERIOD / 4);
         check_value("em_d_oe_o", 32'(em_d_oe), 32'(1));
         check_value("em_d_o", 32'(em_d_out), 32'(16'(base + i)));
         @(negedge clk);
         if (rx_cnt > 0) begin
            rx_cnt--;
         end
      end
      ncs4 = 1'b1;
      noe  = 1'b1;
      check_value("rx_have_data_o", 32'(rx_have_data), 32'(rx_cnt != 0));
   endtask

   task automatic status_read(input logic [31:0] expected);
      ncs6 = 1'b0;
      noe  = 1'b0;
      #(CLK_PERIOD / 4);
      check_value("em_d_oe_o", 32'(em_d_oe), 32'(1));
      check_value("em_d_o", 32'(em_d_out), expected);
      // Same word rebuilt from the testbench's own counts
      check_value("em_d_o", 32'(em_d_out), 32'({8'(tx_cnt), 8'(rx_cnt)}));
      @(negedge clk);
      ncs6 = 1'b1;
      noe  = 1'b1;
      #(CLK_PERIOD / 4);
      check_value("em_d_oe_o", 32'(em_d_oe), 32'(0));
      @(negedge clk);
   endtask

   task automatic stream_push(input logic [31:0] base, input int count);
      int i;
      int waited;
      for (i = 0; i < count; i++) begin
         rx_data    = STREAM_W'(base + i);
         rx_src_rdy = 1'b1;
         waited     = 0;
         while (!rx_dst_rdy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (!rx_dst_rdy) begin
            $display("At %0t ns the receive port never became ready", $time);
            err_cnt++;
            rx_src_rdy = 1'b0;
            return;
         end
         @(negedge clk);
         rx_cnt++;
         check_value("rx_dst_rdy_o", 32'(rx_dst_rdy), 32'(rx_cnt < FIFO_DEPTH));
      end
      rx_src_rdy = 1'b0;
      check_value("rx_have_data_o", 32'(rx_have_data), 32'(rx_cnt != 0));
   endtask

   task automatic stream_pop(input logic [31:0] base, input int count);
      int                  i;
      int                  stall;
      int                  waited;
      logic [STREAM_W-1:0] expected;
      for (i = 0; i < count; i++) begin
         stall      = $random(seed) & 3;
         tx_dst_rdy = 1'b0;
         repeat (stall) @(negedge clk);
         waited = 0;
         while (!tx_src_rdy && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (!tx_src_rdy) begin
            $display("At %0t ns no transmit word was offered for word %0d", $time, i);
            err_cnt++;
            return;
         end
         // End flag on the last word of a frame and start flag on the first
         expected = {tx_frame_pos == FRAME_LEN - 1, tx_frame_pos == 0, 16'(base + i)};
         check_value("tx_data_o", 32'(tx_data), 32'(expected));
         tx_dst_rdy = 1'b1;
         @(negedge clk);
         tx_cnt--;
         tx_frame_pos = (tx_frame_pos == FRAME_LEN - 1) ? 0 : tx_frame_pos + 1;
         check_value("tx_have_space_o", 32'(tx_have_space),
                     32'((FIFO_DEPTH - tx_cnt) >= FRAME_LEN));
         check_value("tx_src_rdy_o", 32'(tx_src_rdy), 32'(tx_cnt != 0));
      end
      tx_dst_rdy = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Trace replay
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int t;
      int errs_before;
      rst        = 1'b1;
      em_d_in    = '0;
      ncs4       = 1'b1;
      ncs6       = 1'b1;
      nwe        = 1'b1;
      noe        = 1'b1;
      tx_dst_rdy = 1'b0;
      rx_data    = '0;
      rx_src_rdy = 1'b0;
      bus_reset  = 1'b0;
      load_trace();
      trace_ready = 1'b1;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      errs_before = err_cnt;
      check_value("tx_src_rdy_o", 32'(tx_src_rdy), 32'(0));
      check_value("bus_error_o", 32'(bus_error), 32'(0));
      check_value("rx_have_data_o", 32'(rx_have_data), 32'(0));
      check_value("em_d_oe_o", 32'(em_d_oe), 32'(0));
      $display("Test 0 (reset) %s", (err_cnt == errs_before) ? "passed" : "failed");

      for (t = 0; t < op_q.size(); t++) begin
         errs_before = err_cnt;
         case (op_q[t])
            "W": bus_write(val_q[t], cnt_q[t]);
            "R": bus_read(val_q[t], cnt_q[t]);
            "P": stream_push(val_q[t], cnt_q[t]);
            "T": stream_pop(val_q[t], cnt_q[t]);
            "S": status_read(val_q[t]);
            "E": check_value("bus_error_o", 32'(bus_error), 32'(val_q[t][0]));
            "C": begin
               bus_reset = 1'b1;
               @(negedge clk);
               bus_reset = 1'b0;
            end
            default: begin
               $display("Trace entry %0d has an unknown operation %c", t + 1, op_q[t]);
               err_cnt++;
            end
         endcase
         $display("Test %0d (%c %h x%0d) %s", t + 1, op_q[t], val_q[t], cnt_q[t],
                  (err_cnt == errs_before) ? "passed" : "failed");
      end

      $display("Tests %0d, checks %0d, errors %0d", op_q.size() + 1, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Budget of 50 cycles per traced word plus slack for reset
   initial begin
      wait (trace_ready);
      repeat ((total_words + 10) * 50) @(posedge clk);
      $display("Timeout after %0d cycles, the trace did not complete", (total_words + 10) * 50);
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: filelist.f
design/gpmc_pkg.sv
design/gpmc_if.sv
design/gpmc_tx_writer.sv
design/gpmc_rx_reader.sv
design/gpmc_bus_mux.sv
design/gpmc_bridge.sv
verif/tb_gpmc_bridge.sv

// File: Makefile
# Verilator build, run, lint and clean for the GPMC stream bridge

TOP := tb_gpmc_bridge

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only --timing --top-module gpmc_bridge \
		design/gpmc_pkg.sv design/gpmc_if.sv design/gpmc_tx_writer.sv \
		design/gpmc_rx_reader.sv design/gpmc_bus_mux.sv design/gpmc_bridge.sv

clean:
	rm -rf obj_dir sim.log

// File: verif/gpmc_trace.txt
# op value count: W write, R read, P stream push, T stream pop, S status word
# E bus error level, C error clear; value in hex, count in decimal (default 1)
S 0000
W 1000 12
S 0C00
T 1000 12
P 3ABC0 5
S 0005
R ABC0 5
S 0000
E 0
R 0000 1
E 1
C
E 0
W 2000 17
E 1
S 1000
T 2000 16
C
E 0
